// File: Bender.yml
package:
  name: board_monitor

sources:
  - src/board_monitor_pkg.sv
  - src/perf_count_if.sv
  - src/apb_monitor_regs.sv
  - src/run_control.sv
  - src/event_counters.sv
  - src/seg_display.sv
  - src/board_monitor_top.sv
  - target: test
    files:
      - verification/board_monitor_tb.sv

// File: project.f
src/board_monitor_pkg.sv
src/perf_count_if.sv
src/apb_monitor_regs.sv
src/run_control.sv
src/event_counters.sv
src/seg_display.sv
src/board_monitor_top.sv
verification/board_monitor_tb.sv

// File: src/apb_monitor_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_monitor_regs import board_monitor_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  apb_addr_t    paddr,
    input  logic [31:0]  pwdata,
    input  logic         halted,
    output logic [31:0]  prdata,
    output logic         pslverr,
    output rate_sel_t    rate_sel,
    output disp_sel_t    disp_sel,
    perf_count_if.regs   counts
);

    ctrl_reg_u   ctrl_q;
    ctrl_reg_u   ctrl_wr;
    logic        access;
    logic [31:0] rd_data;
    logic        err;
    logic        wr_ok;

    assign access = psel && penable;

    // ==================================================
    // address decode
    // ==================================================
    always_comb begin
        rd_data = '0;
        err     = 1'b0;
        case (paddr)
            addr_ctrl: begin
                rd_data = ctrl_q.raw;
            end
            addr_status: begin
                rd_data = {31'b0, halted};
                err     = pwrite;           // read only.
            end
            addr_clear: begin
                rd_data = '0;
            end
            addr_cycles: begin
                rd_data = counts.cycles;
                err     = pwrite;
            end
            addr_jumps: begin
                rd_data = counts.jumps;
                err     = pwrite;
            end
            addr_branches: begin
                rd_data = counts.branches;
                err     = pwrite;
            end
            addr_taken: begin
                rd_data = counts.taken;
                err     = pwrite;
            end
            addr_retired: begin
                rd_data = counts.retired;
                err     = pwrite;
            end
            default: begin
                err = 1'b1;                 // unmapped.
            end
        endcase
    end

    assign wr_ok   = access && pwrite && !err;
    assign prdata  = (access && !pwrite) ? rd_data : '0;
    assign pslverr = access && err;

    // upper bits of the control word are dropped on write
    always_comb begin
        ctrl_wr.raw    = pwdata;
        ctrl_wr.f.zero = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q.raw <= '0;
        end else if (wr_ok && paddr == addr_ctrl) begin
            ctrl_q <= ctrl_wr;
        end
    end

    assign counts.clear = wr_ok && paddr == addr_clear && pwdata[0];
    assign rate_sel     = ctrl_q.f.rate_sel;
    assign disp_sel     = ctrl_q.f.disp_sel;

    // ==================================================
    // checks
    // ==================================================
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    );

    // an apb write takes two cycles, so clear cannot repeat back to back.
    a_clear_one_cycle: assert property (
        @(posedge clk) disable iff (reset) counts.clear |=> !counts.clear
    );

endmodule

`default_nettype wire

// File: src/board_monitor_pkg.sv
`default_nettype none

package board_monitor_pkg;

    // ==================================================
    // data types
    // ==================================================
    typedef logic [31:0] count_t;
    typedef logic [1:0]  rate_sel_t;
    typedef logic [2:0]  disp_sel_t;
    typedef logic [7:0]  apb_addr_t;

    // ==================================================
    // step rates and display scan
    // ==================================================
    localparam int rate_cnt_w = 7;
    localparam logic [rate_cnt_w-1:0] rate_period [4] = '{7'd64, 7'd16, 7'd4, 7'd1};

    localparam disp_sel_t disp_core     = 3'd0;
    localparam disp_sel_t disp_cycles   = 3'd1;
    localparam disp_sel_t disp_jumps    = 3'd2;
    localparam disp_sel_t disp_branches = 3'd3;
    localparam disp_sel_t disp_taken    = 3'd4;
    localparam disp_sel_t disp_retired  = 3'd5;

    localparam int scan_period = 8;  // clk cycles per digit.
    localparam int scan_cnt_w  = $clog2(scan_period);

    // segments gfedcba, active low.
    localparam logic [6:0] seg_table [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    // ==================================================
    // register map
    // ==================================================
    localparam apb_addr_t addr_ctrl     = 8'h00;
    localparam apb_addr_t addr_status   = 8'h04;
    localparam apb_addr_t addr_clear    = 8'h08;
    localparam apb_addr_t addr_cycles   = 8'h10;
    localparam apb_addr_t addr_jumps    = 8'h14;
    localparam apb_addr_t addr_branches = 8'h18;
    localparam apb_addr_t addr_taken    = 8'h1c;
    localparam apb_addr_t addr_retired  = 8'h20;

    typedef struct packed {
        logic [26:0] zero;      // reads back as zero.
        disp_sel_t   disp_sel;
        rate_sel_t   rate_sel;
    } ctrl_fields_t;

    typedef union packed {
        logic [31:0]  raw;      // apb view.
        ctrl_fields_t f;        // field view.
    } ctrl_reg_u;

endpackage

`default_nettype wire

// File: src/board_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_monitor_top import board_monitor_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        resume,
    input  logic        core_halt,
    input  logic        core_is_jump,
    input  logic        core_is_branch,
    input  logic        core_branched,
    input  logic        core_valid_inst,
    input  count_t      core_display,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        core_en,
    output logic [7:0]  seg_n,
    output logic [7:0]  an_n
);

    rate_sel_t rate_sel;
    disp_sel_t disp_sel;
    logic      halted;

    perf_count_if counts0 ();

    apb_monitor_regs regs0 (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .halted   (halted),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .rate_sel (rate_sel),
        .disp_sel (disp_sel),
        .counts   (counts0.regs)
    );

    run_control run0 (
        .clk       (clk),
        .reset     (reset),
        .resume    (resume),
        .core_halt (core_halt),
        .rate_sel  (rate_sel),
        .core_en   (core_en),
        .halted    (halted)
    );

    event_counters ctr0 (
        .clk             (clk),
        .reset           (reset),
        .core_en         (core_en),
        .core_is_jump    (core_is_jump),
        .core_is_branch  (core_is_branch),
        .core_branched   (core_branched),
        .core_valid_inst (core_valid_inst),
        .counts          (counts0.counter)
    );

    seg_display disp0 (
        .clk          (clk),
        .reset        (reset),
        .disp_sel     (disp_sel),
        .core_display (core_display),
        .counts       (counts0.view),
        .seg_n        (seg_n),
        .an_n         (an_n)
    );

endmodule

`default_nettype wire

// File: src/event_counters.sv
`timescale 1ns/1ps
`default_nettype none

module event_counters import board_monitor_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          core_en,
    input  logic          core_is_jump,
    input  logic          core_is_branch,
    input  logic          core_branched,
    input  logic          core_valid_inst,
    perf_count_if.counter counts
);

    logic branches_wrapped;  // taken may pass branches after this.

    // ==================================================
    // counters
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset || counts.clear) begin
            counts.cycles   <= '0;
            counts.jumps    <= '0;
            counts.branches <= '0;
            counts.taken    <= '0;
            counts.retired  <= '0;
        end else if (core_en) begin
            counts.cycles <= counts.cycles + 1'b1;
            if (core_is_jump) begin
                counts.jumps <= counts.jumps + 1'b1;
            end
            if (core_is_branch) begin
                counts.branches <= counts.branches + 1'b1;
            end
            if (core_branched) begin
                counts.taken <= counts.taken + 1'b1;
            end
            if (core_valid_inst) begin
                counts.retired <= counts.retired + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || counts.clear) begin
            branches_wrapped <= 1'b0;
        end else if (core_en && core_is_branch && counts.branches == '1) begin
            branches_wrapped <= 1'b1;
        end
    end

    // a taken branch is always a branch, as reported by the core.
    a_taken_le_branches: assert property (
        @(posedge clk) disable iff (reset)
        !branches_wrapped |-> counts.taken <= counts.branches
    );

endmodule

`default_nettype wire

// File: src/perf_count_if.sv
`timescale 1ns/1ps
`default_nettype none

interface perf_count_if import board_monitor_pkg::*; ();

    count_t cycles;
    count_t jumps;
    count_t branches;
    count_t taken;
    count_t retired;
    logic   clear;      // one cycle, from the register block.

    modport counter (
        output cycles, jumps, branches, taken, retired,
        input  clear
    );

    modport regs (
        input  cycles, jumps, branches, taken, retired,
        output clear
    );

    modport view (
        input cycles, jumps, branches, taken, retired
    );

endinterface

`default_nettype wire

// File: src/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control import board_monitor_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      resume,
    input  logic      core_halt,
    input  rate_sel_t rate_sel,
    output logic      core_en,
    output logic      halted
);

    logic [rate_cnt_w-1:0] step_cnt;
    rate_sel_t             rate_q;
    logic                  rate_change;
    logic                  tick;
    logic                  resume_q;
    logic                  resume_edge;
    logic                  halt_set;
    logic                  halted_next;

    // ==================================================
    // step tick
    // ==================================================
    assign rate_change = rate_sel != rate_q;
    assign tick        = step_cnt == '0 && !rate_change;

    always_ff @(posedge clk) begin
        if (reset) begin
            rate_q   <= '0;
            step_cnt <= rate_period[0] - 1'b1;
        end else begin
            rate_q <= rate_sel;
            if (rate_change || tick) begin
                step_cnt <= rate_period[rate_sel] - 1'b1;  // restart the period.
            end else begin
                step_cnt <= step_cnt - 1'b1;
            end
        end
    end

    // ==================================================
    // halt and resume
    // ==================================================
    assign resume_edge = resume && !resume_q;
    assign halt_set    = core_en && core_halt;          // halting step.
    assign halted_next = halt_set || (halted && !resume_edge);

    always_ff @(posedge clk) begin
        if (reset) begin
            resume_q <= 1'b0;
            halted   <= 1'b0;
            core_en  <= 1'b0;
        end else begin
            resume_q <= resume;
            halted   <= halted_next;
            core_en  <= tick && !halted_next;
        end
    end

    a_no_step_when_halted: assert property (
        @(posedge clk) disable iff (reset) halted |-> !core_en
    );

endmodule

`default_nettype wire

// File: src/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display import board_monitor_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  disp_sel_t    disp_sel,
    input  count_t       core_display,
    perf_count_if.view   counts,
    output logic [7:0]   seg_n,
    output logic [7:0]   an_n
);

    count_t                src_word;
    logic [scan_cnt_w-1:0] scan_cnt;
    logic [2:0]            digit_idx;
    logic [3:0]            nibble;

    // ==================================================
    // source select
    // ==================================================
    always_comb begin
        case (disp_sel)
            disp_core:     src_word = core_display;
            disp_cycles:   src_word = counts.cycles;
            disp_jumps:    src_word = counts.jumps;
            disp_branches: src_word = counts.branches;
            disp_taken:    src_word = counts.taken;
            disp_retired:  src_word = counts.retired;
            default:       src_word = core_display;  // codes 6 and 7.
        endcase
    end

    // ==================================================
    // digit scan
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == scan_cnt_w'(scan_period - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = src_word[{digit_idx, 2'b00} +: 4];

    always_ff @(posedge clk) begin
        if (reset) begin
            an_n <= 8'hfe;                       // digit 0.
        end else begin
            an_n <= ~(8'b1 << digit_idx);
        end
    end

    always_ff @(posedge clk) begin
        seg_n <= {1'b1, seg_table[nibble]};      // decimal point off.
    end

    a_one_digit_on: assert property (
        @(posedge clk) disable iff (reset) $onehot(~an_n)
    );

endmodule

`default_nettype wire

// File: verification/board_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_monitor_tb import board_monitor_pkg::*; ();

    typedef enum logic [2:0] {
        op_write, op_read, op_counts, op_steps, op_rate, op_halt, op_resume, op_disp
    } op_t;

    typedef struct packed {
        op_t         op;
        apb_addr_t   addr;
        logic [7:0]  arg;       // steps, rate or display code.
        logic [31:0] data;
        logic        err;       // expected pslverr.
    } row_t;

    localparam int n_rows = 36;
    localparam int step_spacing [4] = '{64, 16, 4, 1};
    localparam logic [7:0] seg_hex [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    row_t rows [n_rows] = '{
        '{op_read, addr_ctrl, 8'd0, 32'h0, 1'b0}, '{op_counts, 8'h0, 8'd0, 32'h0, 1'b0},
        '{op_read, addr_status, 8'd0, 32'h0, 1'b0},
        '{op_write, addr_ctrl, 8'd0, 32'hffff_ffe6, 1'b0},
        '{op_read, addr_ctrl, 8'd0, 32'h0, 1'b0}, '{op_write, addr_ctrl, 8'd0, 32'h0, 1'b0},
        '{op_read, 8'h0c, 8'd0, 32'h0, 1'b1}, '{op_write, 8'h40, 8'd0, 32'h5, 1'b1},
        '{op_write, addr_cycles, 8'd0, 32'h7, 1'b1}, '{op_write, addr_status, 8'd0, 32'h1, 1'b1},
        '{op_read, 8'h24, 8'd0, 32'h0, 1'b1},
        '{op_rate, 8'h0, 8'd0, 32'h0, 1'b0}, '{op_rate, 8'h0, 8'd1, 32'h0, 1'b0},
        '{op_rate, 8'h0, 8'd2, 32'h0, 1'b0}, '{op_rate, 8'h0, 8'd3, 32'h0, 1'b0},
        '{op_steps, 8'h0, 8'd40, 32'h0, 1'b0}, '{op_counts, 8'h0, 8'd0, 32'h0, 1'b0},
        '{op_steps, 8'h0, 8'd25, 32'h0, 1'b0}, '{op_counts, 8'h0, 8'd0, 32'h0, 1'b0},
        '{op_write, addr_clear, 8'd0, 32'h1, 1'b0}, '{op_counts, 8'h0, 8'd0, 32'h0, 1'b0},
        '{op_steps, 8'h0, 8'd30, 32'h0, 1'b0}, '{op_counts, 8'h0, 8'd0, 32'h0, 1'b0},
        '{op_halt, 8'h0, 8'd0, 32'h0, 1'b0}, '{op_read, addr_status, 8'd0, 32'h0, 1'b0},
        '{op_disp, 8'h0, 8'd0, 32'h89ab_cdef, 1'b0}, '{op_disp, 8'h0, 8'd1, 32'h0, 1'b0},
        '{op_disp, 8'h0, 8'd2, 32'h0, 1'b0}, '{op_disp, 8'h0, 8'd3, 32'h0, 1'b0},
        '{op_disp, 8'h0, 8'd4, 32'h0, 1'b0}, '{op_disp, 8'h0, 8'd5, 32'h0, 1'b0},
        '{op_disp, 8'h0, 8'd6, 32'h0123_4567, 1'b0},
        '{op_resume, 8'h0, 8'd0, 32'h0, 1'b0}, '{op_read, addr_status, 8'd0, 32'h0, 1'b0},
        '{op_steps, 8'h0, 8'd20, 32'h0, 1'b0}, '{op_counts, 8'h0, 8'd0, 32'h0, 1'b0}
    };

    logic clk = 1'b0;
    logic reset, resume, core_halt, core_is_jump, core_is_branch, core_branched, core_valid_inst;
    logic psel, penable, pwrite, pslverr, core_en;
    count_t      core_display;
    apb_addr_t   paddr;
    logic [31:0] pwdata, prdata;
    logic [7:0]  seg_n, an_n;

    // reference model state.
    count_t      m_cnt [5];     // cycles, jumps, branches, taken, retired.
    logic        m_halted, m_resume_q, en_seen;
    ctrl_reg_u   m_ctrl;
    count_t      snap_cnt [5];
    logic        snap_halted;
    logic [31:0] rng = 32'd37;

    board_monitor_top dut0 (.*);

    always #50 clk = ~clk;

    always @(negedge clk) en_seen = core_en;

    // ==================================================
    // reference model
    // ==================================================
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 5; i++) m_cnt[i] = '0;
            m_halted   = 1'b0;
            m_resume_q = 1'b0;
            m_ctrl.raw = '0;
        end else begin
            if (psel && penable && pwrite && paddr == addr_clear && pwdata[0]) begin
                for (int i = 0; i < 5; i++) m_cnt[i] = '0;   // clear beats a step.
            end else if (en_seen) begin
                m_cnt[0] = m_cnt[0] + 1;
                m_cnt[1] = m_cnt[1] + core_is_jump;
                m_cnt[2] = m_cnt[2] + core_is_branch;
                m_cnt[3] = m_cnt[3] + core_branched;
                m_cnt[4] = m_cnt[4] + core_valid_inst;
            end
            if (psel && penable && pwrite && paddr == addr_ctrl) begin
                m_ctrl.raw = {27'b0, pwdata[4:0]};   // rate and display fields only.
            end
            if (en_seen && core_halt) m_halted = 1'b1;
            else if (resume && !m_resume_q) m_halted = 1'b0;
            m_resume_q = resume;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ==================================================
    // checks
    // ==================================================
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_run($sformatf("[FAIL] %0t: %s", $time, what));
    endtask

    task automatic check_count(input string what, input count_t got, input count_t exp);
        if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_ctrl(input ctrl_reg_u got, input ctrl_reg_u exp);
        if (got !== exp) report_mismatch($sformatf("ctrl is %h, expected %h", got.raw, exp.raw));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_segments(input logic [7:0] seg, an, exp_seg, exp_an);
        if (seg !== exp_seg || an !== exp_an) begin
            report_mismatch($sformatf("seg_n/an_n are %h/%h, expected %h/%h",
                                      seg, an, exp_seg, exp_an));
        end
    endtask

    // ==================================================
    // bus and wait helpers
    // ==================================================
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;                 // access phase.
        #10;
        rdata       = prdata;
        err         = pslverr;
        snap_cnt    = m_cnt;
        snap_halted = m_halted;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_check(input apb_addr_t addr, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        ctrl_reg_u   got;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        got.raw = rdata;
        check_bit("pslverr", err, exp_err);
        if (addr == addr_ctrl) check_ctrl(got, m_ctrl);
        else if (addr == addr_status) check_bit("status halted", rdata[0], snap_halted);
        else if (addr >= addr_cycles && addr <= addr_retired && addr[1:0] == 2'b00)
            check_count($sformatf("counter at %h", addr), rdata, snap_cnt[(addr - 8'h10) >> 2]);
        else check_count("unmapped read", rdata, '0);
    endtask

    task automatic wait_pulse(input string why);
        int n;
        n = 0;
        while (!core_en) begin
            @(negedge clk);
            n++;
            if (n > 200) stop_run({"timeout: no core_en pulse came for ", why});
        end
    endtask

    task automatic wait_digit(input logic [7:0] target);
        int n;
        n = 0;
        while (an_n == target) begin    // let a stale slot pass.
            @(negedge clk);
            n++;
            if (n > 100) stop_run("timeout: the display never left the current digit");
        end
        n = 0;
        while (an_n != target) begin
            @(negedge clk);
            n++;
            if (n > 100) stop_run("timeout: the display never reached the expected digit");
        end
    endtask

    task automatic run_row(input row_t rw);
        logic [31:0] rdata;
        logic        err;
        count_t      gap, word;
        logic [7:0]  target;
        case (rw.op)
            op_write: begin
                apb_xfer(1'b1, rw.addr, rw.data, rdata, err);
                check_bit("pslverr", err, rw.err);
            end
            op_read: read_check(rw.addr, rw.err);
            op_counts: for (int i = 0; i < 5; i++) read_check(addr_cycles + 8'(4 * i), 1'b0);
            op_steps: begin
                rng             = xorshift(rng);
                core_is_jump    = rng[0];
                core_is_branch  = rng[1];
                core_branched   = rng[1] & rng[2];   // only a branch can be taken.
                core_valid_inst = rng[3];
                repeat (rw.arg) begin
                    wait_pulse("a core step");
                    @(negedge clk);
                end
            end
            op_rate: begin
                apb_xfer(1'b1, addr_ctrl, {27'b0, m_ctrl.f.disp_sel, rw.arg[1:0]}, rdata, err);
                check_bit("pslverr", err, 1'b0);
                repeat (2) begin
                    wait_pulse("a step after the rate change");
                    @(negedge clk);
                end
                gap = 1;
                while (!core_en) begin
                    @(negedge clk);
                    gap++;
                    if (gap > 200) stop_run("timeout: core_en never pulsed a second time");
                end
                check_count("step spacing", gap, count_t'(step_spacing[rw.arg]));
            end
            op_halt: begin
                core_halt = 1'b1;
                wait_pulse("the halting step");
                @(negedge clk);
                core_halt = 1'b0;
                repeat (200) begin
                    @(negedge clk);
                    check_bit("core_en while halted", core_en, 1'b0);
                end
            end
            op_resume: begin
                resume = 1'b1;
                @(negedge clk);
                resume = 1'b0;
            end
            op_disp: begin
                core_display = rw.data;
                apb_xfer(1'b1, addr_ctrl, {27'b0, rw.arg[2:0], m_ctrl.f.rate_sel}, rdata, err);
                word = (rw.arg == 0 || rw.arg > 5) ? core_display : m_cnt[rw.arg - 1];
                for (int k = 0; k < 8; k++) begin
                    target = ~(8'b1 << k);
                    wait_digit(target);
                    check_segments(seg_n, an_n, seg_hex[word[4 * k +: 4]], target);
                end
            end
            default: stop_run("unknown stimulus row kind");
        endcase
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        reset           = 1'b1;
        resume          = 1'b0;
        core_halt       = 1'b0;
        core_is_jump    = 1'b0;
        core_is_branch  = 1'b0;
        core_branched   = 1'b0;
        core_valid_inst = 1'b0;
        core_display    = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < n_rows; r++) run_row(rows[r]);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
